// ==== rtl/io_map_pkg.sv ====
package io_map_pkg;

  localparam int IO_DATA_W = 16;

  typedef logic [IO_DATA_W-1:0] io_data_t;
  typedef logic [15:0]          io_addr_t;

  // Peripheral register addresses as seen by the CPU
  localparam io_addr_t ADDR_PIOS        = 16'd8;
  localparam io_addr_t ADDR_INT_FLAGS   = 16'd40;
  localparam io_addr_t ADDR_INT_MASK    = 16'd50;
  localparam io_addr_t ADDR_TICKS_SL    = 16'd105;
  localparam io_addr_t ADDR_TICKS_SH    = 16'd106;
  localparam io_addr_t ADDR_TICKS_SHH   = 16'd107;
  localparam io_addr_t ADDR_TICK_SAMPLE = 16'd109;
  localparam io_addr_t ADDR_TIMER1_CL   = 16'd110;
  localparam io_addr_t ADDR_TIMER1_CH   = 16'd111;
  localparam io_addr_t ADDR_PORTA_IN    = 16'd310;
  localparam io_addr_t ADDR_PORTA_OUT   = 16'd311;
  localparam io_addr_t ADDR_PORTA_DIR   = 16'd312;

  // CPU strobe bus, rd and wr last a single cycle
  typedef struct packed {
    logic     rd;
    logic     wr;
    io_addr_t addr;
    io_data_t wdata;
  } io_bus_t;

  // Decoded write strobes for the peripheral blocks
  typedef struct packed {
    logic pios;
    logic porta_out;
    logic porta_dir;
    logic timer1_cl;
    logic timer1_ch;
    logic tick_sample;
  } io_wstb_t;

endpackage

// ==== rtl/periph_pkg.sv ====
package periph_pkg;

  // Interrupt levels and external sources
  localparam int IRQ_N     = 8;
  localparam int EXT_IRQ_N = 4;

  // Periodic timer raises the highest level
  localparam int IRQ_TIMER1 = 7;

  // Flip-flop stages on each external interrupt input
  localparam int SYNC_DEPTH = 3;

  typedef logic [IRQ_N-1:0]     irq_vec_t;
  typedef logic [EXT_IRQ_N-1:0] ext_irq_t;

  // Free-running tick counter value
  typedef logic [47:0] tick_t;

  // Reload timer count
  typedef logic [31:0] timer_t;

  // Direct pin control register
  typedef logic [2:0] pios_t;

  // General-purpose port, one bit per pin
  typedef logic [15:0] port_t;

endpackage

// ==== rtl/io_regs.sv ====
module io_regs
  import io_map_pkg::*, periph_pkg::*;
(
  input  logic     clk,
  input  logic     resetq,
  input  io_bus_t  bus,
  output io_data_t io_din,
  output io_wstb_t wstb,
  output irq_vec_t int_flags,
  output irq_vec_t int_mask,
  input  tick_t    tick_snap,
  input  port_t    porta_rd,
  input  port_t    porta_out,
  input  port_t    porta_oe,
  input  pios_t    pios
);

  logic sel_pios;
  logic sel_flags;
  logic sel_mask;
  logic sel_snap_l;
  logic sel_snap_h;
  logic sel_snap_hh;
  logic sel_porta_in;
  logic sel_porta_out;
  logic sel_porta_dir;

  // Gate one register onto the read bus
  function automatic io_data_t rd_term(input logic sel, input io_data_t val);
    return sel ? val : '0;
  endfunction

  // Single address decode shared by reads and writes
  assign sel_pios      = (bus.addr == ADDR_PIOS);
  assign sel_flags     = (bus.addr == ADDR_INT_FLAGS);
  assign sel_mask      = (bus.addr == ADDR_INT_MASK);
  assign sel_snap_l    = (bus.addr == ADDR_TICKS_SL);
  assign sel_snap_h    = (bus.addr == ADDR_TICKS_SH);
  assign sel_snap_hh   = (bus.addr == ADDR_TICKS_SHH);
  assign sel_porta_in  = (bus.addr == ADDR_PORTA_IN);
  assign sel_porta_out = (bus.addr == ADDR_PORTA_OUT);
  assign sel_porta_dir = (bus.addr == ADDR_PORTA_DIR);

  // Strobes for registers that live in the other blocks
  assign wstb.pios        = bus.wr & sel_pios;
  assign wstb.porta_out   = bus.wr & sel_porta_out;
  assign wstb.porta_dir   = bus.wr & sel_porta_dir;
  assign wstb.timer1_cl   = bus.wr & (bus.addr == ADDR_TIMER1_CL);
  assign wstb.timer1_ch   = bus.wr & (bus.addr == ADDR_TIMER1_CH);
  assign wstb.tick_sample = bus.wr & (bus.addr == ADDR_TICK_SAMPLE);

  // Mask starts closed, flags start armed
  always_ff @(posedge clk)
  begin
    if (!resetq)
    begin
      int_mask  <= '0;
      int_flags <= '1;
    end
    else if (bus.wr)
    begin
      if (sel_mask)
        int_mask <= bus.wdata[IRQ_N-1:0];
      if (sel_flags)
        int_flags <= bus.wdata[IRQ_N-1:0];
    end
  end

  // Combinational read, unmapped addresses give 0
  assign io_din = rd_term(sel_pios,      io_data_t'(pios))       |
                  rd_term(sel_flags,     io_data_t'(int_flags))  |
                  rd_term(sel_mask,      io_data_t'(int_mask))   |
                  rd_term(sel_snap_l,    tick_snap[15:0])        |
                  rd_term(sel_snap_h,    tick_snap[31:16])       |
                  rd_term(sel_snap_hh,   tick_snap[47:32])       |
                  rd_term(sel_porta_in,  porta_rd)               |
                  rd_term(sel_porta_out, porta_out)              |
                  rd_term(sel_porta_dir, porta_oe);

endmodule

// ==== rtl/irq_ctrl.sv ====
module irq_ctrl
  import periph_pkg::*;
(
  input  logic     clk,
  input  logic     resetq,
  input  ext_irq_t intr,
  input  logic     timer_hit,
  input  irq_vec_t int_flags,
  input  irq_vec_t int_mask,
  output irq_vec_t pending,
  output irq_vec_t int_rqst
);

  ext_irq_t ext_rise;
  irq_vec_t set_vec;

  // One synchroniser and edge detector per external line
  for (genvar i = 0; i < EXT_IRQ_N; i++)
  begin : g_ext
    logic [SYNC_DEPTH-1:0] sync_q;

    always_ff @(posedge clk)
    begin
      if (!resetq)
        sync_q <= '0;
      else
        sync_q <= {sync_q[SYNC_DEPTH-2:0], intr[i]};
    end

    // Rising edge seen between the last two stages
    assign ext_rise[i] = sync_q[SYNC_DEPTH-2] & ~sync_q[SYNC_DEPTH-1];
  end

  // Levels 4 to 6 have no source
  always_comb
  begin
    set_vec                = '0;
    set_vec[EXT_IRQ_N-1:0] = ext_rise;
    set_vec[IRQ_TIMER1]    = timer_hit;
  end

  // A new event wins over a clear in the same cycle
  always_ff @(posedge clk)
  begin
    if (!resetq)
      pending <= '0;
    else
      pending <= set_vec | (pending & int_flags);
  end

  assign int_rqst = pending & int_mask;

endmodule

// ==== rtl/tick_timer.sv ====
module tick_timer
  import io_map_pkg::*, periph_pkg::*;
(
  input  logic     clk,
  input  logic     resetq,
  input  io_wstb_t wstb,
  input  io_data_t wdata,
  input  logic     timer_pending,
  output tick_t    tick_snap,
  output logic     timer_hit
);

  tick_t  ticks;
  timer_t reload_q;
  timer_t timer1;

  // Free-running counter, zero in the first cycle out of reset
  always_ff @(posedge clk)
  begin
    if (!resetq)
      ticks <= '0;
    else
      ticks <= ticks + 1'b1;
  end

  // Snapshot keeps the count present at the sample write
  always_ff @(posedge clk)
  begin
    if (!resetq)
      tick_snap <= '0;
    else if (wstb.tick_sample)
      tick_snap <= ticks;
  end

  // Reload value arrives in two halves, low half first
  always_ff @(posedge clk)
  begin
    if (!resetq)
      reload_q <= '0;
    else if (wstb.timer1_cl)
      reload_q[15:0] <= wdata;
    else if (wstb.timer1_ch)
      reload_q[31:16] <= wdata;
  end

  // High half write starts a period straight away
  always_ff @(posedge clk)
  begin
    if (!resetq)
      timer1 <= '0;
    else if (wstb.timer1_ch)
      timer1 <= {wdata, reload_q[15:0]};
    else if (timer_pending)
      timer1 <= reload_q;
    else
      timer1 <= timer1 - 1'b1;
  end

  // Pending bit follows one edge later, closing a period of N cycles
  assign timer_hit = (timer1 == timer_t'(1));

endmodule

// ==== rtl/gpio_port.sv ====
module gpio_port
  import io_map_pkg::*, periph_pkg::*;
(
  input  logic     clk,
  input  logic     resetq,
  input  io_wstb_t wstb,
  input  io_data_t wdata,
  input  port_t    porta_in,
  output port_t    porta_rd,
  output port_t    porta_out,
  output port_t    porta_oe,
  output pios_t    pios
);

  port_t dir_q;
  port_t out_q;
  pios_t pios_q;

  // All pins come out of reset as inputs
  always_ff @(posedge clk)
  begin
    if (!resetq)
    begin
      dir_q  <= '0;
      out_q  <= '0;
      pios_q <= '0;
    end
    else
    begin
      if (wstb.porta_dir)
        dir_q <= wdata;
      if (wstb.porta_out)
        out_q <= wdata;
      if (wstb.pios)
        pios_q <= wdata[$bits(pios_t)-1:0];
    end
  end

  // Pin value as a bidirectional pad would show it
  assign porta_rd = (out_q & dir_q) | (porta_in & ~dir_q);

  assign porta_out = out_q;
  assign porta_oe  = dir_q;
  assign pios      = pios_q;

endmodule

// ==== rtl/j1_io_top.sv ====
module j1_io_top
  import io_map_pkg::*, periph_pkg::*;
(
  input  logic     clk,
  input  logic     resetq,
  input  io_bus_t  bus,
  output io_data_t io_din,
  input  ext_irq_t intr,
  output irq_vec_t int_rqst,
  input  port_t    porta_in,
  output port_t    porta_out,
  output port_t    porta_oe,
  output pios_t    pios
);

  io_wstb_t wstb;
  irq_vec_t int_flags;
  irq_vec_t int_mask;
  irq_vec_t pending;
  tick_t    tick_snap;
  port_t    porta_rd;
  logic     timer_hit;

  io_regs u_io_regs (
    .clk       (clk),
    .resetq    (resetq),
    .bus       (bus),
    .io_din    (io_din),
    .wstb      (wstb),
    .int_flags (int_flags),
    .int_mask  (int_mask),
    .tick_snap (tick_snap),
    .porta_rd  (porta_rd),
    .porta_out (porta_out),
    .porta_oe  (porta_oe),
    .pios      (pios)
  );

  irq_ctrl u_irq_ctrl (
    .clk       (clk),
    .resetq    (resetq),
    .intr      (intr),
    .timer_hit (timer_hit),
    .int_flags (int_flags),
    .int_mask  (int_mask),
    .pending   (pending),
    .int_rqst  (int_rqst)
  );

  // Timer reloads while its own level is pending
  tick_timer u_tick_timer (
    .clk           (clk),
    .resetq        (resetq),
    .wstb          (wstb),
    .wdata         (bus.wdata),
    .timer_pending (pending[IRQ_TIMER1]),
    .tick_snap     (tick_snap),
    .timer_hit     (timer_hit)
  );

  gpio_port u_gpio_port (
    .clk       (clk),
    .resetq    (resetq),
    .wstb      (wstb),
    .wdata     (bus.wdata),
    .porta_in  (porta_in),
    .porta_rd  (porta_rd),
    .porta_out (porta_out),
    .porta_oe  (porta_oe),
    .pios      (pios)
  );

endmodule

// ==== verification/j1_io_chk.sv ====
module irq_regs_chk
  import periph_pkg::*;
(
  input logic     clk,
  input logic     resetq,
  input irq_vec_t int_flags,
  input irq_vec_t int_mask,
  input irq_vec_t pending,
  input irq_vec_t int_rqst
);

  // A request only leaves through an open mask bit
  a_rqst_masked: assert property (@(posedge clk) disable iff (!resetq)
    (int_rqst & ~int_mask) == 8'h00)
    else $error("int_rqst has a bit set where int_mask is 0");

  // Levels 4 to 6 have no source
  a_unused_levels: assert property (@(posedge clk) disable iff (!resetq)
    pending[6:4] == 3'b000)
    else $error("pending bit 4, 5 or 6 is set");

  a_flags_reset: assert property (@(posedge clk)
    $rose(resetq) |-> int_flags == 8'hff)
    else $error("int_flags is not all ones after reset");

endmodule

bind irq_ctrl irq_regs_chk u_irq_regs_chk (
  .clk       (clk),
  .resetq    (resetq),
  .int_flags (int_flags),
  .int_mask  (int_mask),
  .pending   (pending),
  .int_rqst  (int_rqst)
);

// ==== verification/tb_j1_io.sv ====
module tb_j1_io
  import io_map_pkg::*, periph_pkg::*;
();

  localparam int CYCLE_LIMIT = 4000;

  logic     clk;
  logic     resetq;
  io_bus_t  bus;
  io_data_t io_din;
  ext_irq_t intr;
  irq_vec_t int_rqst;
  port_t    porta_in;
  port_t    porta_out;
  port_t    porta_oe;
  pios_t    pios;

  integer   seed;
  int       cycle_cnt;
  int       data_errs;
  int       irq_errs;
  int       port_errs;

  // Reference model, updated from the driven bus on the DUT's edges
  irq_vec_t m_mask;
  irq_vec_t m_flags;
  irq_vec_t m_pending;
  port_t    m_out;
  port_t    m_dir;
  tick_t    m_ticks;
  timer_t   m_reload;
  timer_t   m_timer;
  ext_irq_t intr_last;
  ext_irq_t rise_d1;
  ext_irq_t rise_d2;

  j1_io_top uut (
    .clk       (clk),
    .resetq    (resetq),
    .bus       (bus),
    .io_din    (io_din),
    .intr      (intr),
    .int_rqst  (int_rqst),
    .porta_in  (porta_in),
    .porta_out (porta_out),
    .porta_oe  (porta_oe),
    .pios      (pios)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk)
  begin
    if (!resetq)
    begin
      m_mask    <= '0;
      m_flags   <= '1;
      m_pending <= '0;
      m_out     <= '0;
      m_dir     <= '0;
      m_ticks   <= '0;
      m_reload  <= '0;
      m_timer   <= '0;
      intr_last <= '0;
      rise_d1   <= '0;
      rise_d2   <= '0;
    end
    else
    begin
      m_ticks   <= m_ticks + 48'd1;
      intr_last <= intr;
      // An input edge reaches its pending bit on the third edge
      rise_d1   <= intr & ~intr_last;
      rise_d2   <= rise_d1;
      m_pending <= {(m_timer == 32'd1), 3'b000, rise_d2} | (m_pending & m_flags);
      m_timer   <= m_pending[IRQ_TIMER1] ? m_reload : m_timer - 32'd1;
      if (bus.wr)
      begin
        case (bus.addr)
          ADDR_INT_FLAGS: m_flags <= bus.wdata[7:0];
          ADDR_INT_MASK:  m_mask <= bus.wdata[7:0];
          ADDR_PORTA_OUT: m_out <= bus.wdata;
          ADDR_PORTA_DIR: m_dir <= bus.wdata;
          ADDR_TIMER1_CL: m_reload[15:0] <= bus.wdata;
          ADDR_TIMER1_CH:
          begin
            m_reload[31:16] <= bus.wdata;
            m_timer         <= {bus.wdata, m_reload[15:0]};
          end
          default: ;
        endcase
      end
    end
  end

  task automatic check_data(input string name, input io_data_t act, input io_data_t exp);
    if (act !== exp)
    begin
      data_errs++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_irq(input string name, input irq_vec_t act, input irq_vec_t exp);
    if (act !== exp)
    begin
      irq_errs++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_port(input string name, input port_t act, input port_t exp);
    if (act !== exp)
    begin
      port_errs++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  function automatic logic is_mapped(input io_addr_t a);
    return a inside {ADDR_PIOS, ADDR_INT_FLAGS, ADDR_INT_MASK, ADDR_TICKS_SL, ADDR_TICKS_SH,
                     ADDR_TICKS_SHH, ADDR_TICK_SAMPLE, ADDR_TIMER1_CL, ADDR_TIMER1_CH,
                     ADDR_PORTA_IN, ADDR_PORTA_OUT, ADDR_PORTA_DIR};
  endfunction

  // Inputs change 2 time units after the clock edge
  task automatic next_cycle(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic write_reg(input io_addr_t addr, input io_data_t data);
    bus.rd    = 1'b0;
    bus.wr    = 1'b1;
    bus.addr  = addr;
    bus.wdata = data;
    next_cycle(1);
    bus.wr = 1'b0;
  endtask

  task automatic read_check(input io_addr_t addr, input io_data_t exp, input string name);
    bus.rd   = 1'b1;
    bus.addr = addr;
    #1;
    check_data(name, io_din, exp);
    @(posedge clk);
    #2;
    bus.rd = 1'b0;
  endtask

  task automatic readback_registers();
    logic [31:0] rnd;
    io_addr_t    a;
    repeat (4)
    begin
      rnd = $random(seed);
      write_reg(ADDR_PIOS, rnd[15:0]);
      read_check(ADDR_PIOS, {13'd0, rnd[2:0]}, "pios");
      check_data("pios pins", io_data_t'(pios), {13'd0, rnd[2:0]});
      write_reg(ADDR_INT_MASK, rnd[31:16]);
      read_check(ADDR_INT_MASK, {8'd0, rnd[23:16]}, "int_mask");
      rnd = $random(seed);
      write_reg(ADDR_INT_FLAGS, rnd[15:0]);
      read_check(ADDR_INT_FLAGS, {8'd0, rnd[7:0]}, "int_flags");
      write_reg(ADDR_PORTA_OUT, rnd[31:16]);
      read_check(ADDR_PORTA_OUT, rnd[31:16], "porta_out reg");
      rnd = $random(seed);
      write_reg(ADDR_PORTA_DIR, rnd[15:0]);
      read_check(ADDR_PORTA_DIR, rnd[15:0], "porta_dir reg");
    end
    repeat (8)
    begin
      rnd = $random(seed);
      a   = {7'd0, rnd[8:0]};
      while (is_mapped(a))
      begin
        rnd = $random(seed);
        a   = {7'd0, rnd[8:0]};
      end
      read_check(a, 16'h0000, "unmapped read");
    end
  endtask

  task automatic drive_port();
    logic [31:0] rnd;
    port_t       out_v;
    port_t       dir_v;
    repeat (10)
    begin
      rnd      = $random(seed);
      porta_in = rnd[15:0];
      out_v    = rnd[31:16];
      rnd      = $random(seed);
      dir_v    = rnd[15:0];
      write_reg(ADDR_PORTA_OUT, out_v);
      write_reg(ADDR_PORTA_DIR, dir_v);
      check_port("porta_oe", porta_oe, dir_v);
      check_port("porta_out", porta_out, out_v);
      read_check(ADDR_PORTA_IN, (out_v & dir_v) | (porta_in & ~dir_v), "porta_in read");
      // Only input pins follow a new pad value
      porta_in = rnd[31:16];
      read_check(ADDR_PORTA_IN, (m_out & m_dir) | (porta_in & ~m_dir), "porta_in read");
    end
  endtask

  task automatic sample_ticks();
    logic [31:0] rnd;
    tick_t       snap;
    repeat (6)
    begin
      rnd = $random(seed);
      next_cycle(1 + int'(rnd[5:0]));
      snap = m_ticks;
      write_reg(ADDR_TICK_SAMPLE, rnd[31:16]);
      read_check(ADDR_TICKS_SL, snap[15:0], "ticks low");
      read_check(ADDR_TICKS_SH, snap[31:16], "ticks high");
      read_check(ADDR_TICKS_SHH, snap[47:32], "ticks top");
    end
  endtask

  task automatic pulse_ext_irqs();
    logic [31:0] rnd;
    irq_vec_t    clr;
    repeat (8)
    begin
      intr = '0;
      rnd  = $random(seed);
      write_reg(ADDR_INT_MASK, {8'd0, rnd[7:0]});
      write_reg(ADDR_INT_FLAGS, 16'h00ff);
      next_cycle(2);
      intr = rnd[11:8];
      next_cycle(4);
      check_irq("int_rqst", int_rqst, m_pending & m_mask);
      check_irq("int_rqst edges", int_rqst & irq_vec_t'(intr), irq_vec_t'(intr) & m_mask);
      clr = irq_vec_t'(rnd[15:12]);
      write_reg(ADDR_INT_FLAGS, {8'd0, ~clr});
      next_cycle(1);
      check_irq("int_rqst cleared", int_rqst & clr, 8'h00);
      check_irq("int_rqst", int_rqst, m_pending & m_mask);
      // Inputs stay high, so re-arming brings nothing back
      write_reg(ADDR_INT_FLAGS, 16'h00ff);
      next_cycle(4);
      check_irq("int_rqst re-armed", int_rqst & clr, 8'h00);
      check_irq("int_rqst", int_rqst, m_pending & m_mask);
    end
  endtask

  // Level 7 rises exactly n edges after the starting write
  task automatic measure_period(input int n);
    next_cycle(n - 1);
    check_irq("int_rqst[7] early", int_rqst & 8'h80, 8'h00);
    check_irq("int_rqst", int_rqst, m_pending & m_mask);
    next_cycle(1);
    check_irq("int_rqst[7] due", int_rqst & 8'h80, 8'h80);
    check_irq("int_rqst", int_rqst, m_pending & m_mask);
  endtask

  task automatic run_timer();
    logic [31:0] rnd;
    int          n;
    intr = '0;
    rnd  = $random(seed);
    n    = 2 + int'(rnd[7:0]) % 199;
    write_reg(ADDR_INT_FLAGS, 16'h00ff);
    write_reg(ADDR_INT_MASK, 16'h0080);
    write_reg(ADDR_TIMER1_CL, io_data_t'(n));
    write_reg(ADDR_TIMER1_CH, 16'h0000);
    measure_period(n);
    write_reg(ADDR_INT_FLAGS, 16'h007f);
    write_reg(ADDR_INT_FLAGS, 16'h00ff);
    measure_period(n);
  endtask

  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial
  begin
    seed      = 32'hfd75d5c6;
    data_errs = 0;
    irq_errs  = 0;
    port_errs = 0;
    bus       = '0;
    intr      = '0;
    porta_in  = '0;
    resetq    = 1'b0;
    repeat (3) @(posedge clk);
    #2;
    resetq = 1'b1;
    readback_registers();
    drive_port();
    sample_ticks();
    pulse_ext_irqs();
    run_timer();
    $display("Error counts: data %0d, irq %0d, port %0d", data_errs, irq_errs, port_errs);
    if (data_errs + irq_errs + port_errs == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== build.f ====
rtl/io_map_pkg.sv
rtl/periph_pkg.sv
rtl/io_regs.sv
rtl/irq_ctrl.sv
rtl/tick_timer.sv
rtl/gpio_port.sv
rtl/j1_io_top.sv
verification/j1_io_chk.sv
verification/tb_j1_io.sv

// ==== Makefile ====
TOP  = tb_j1_io
SRCS = $(shell cat build.f)

all: run

obj_dir/V$(TOP): build.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f build.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx 'TEST RESULT: PASS'

clean:
	rm -rf obj_dir

.PHONY: all run clean
